// File: logic/isaPkg.sv
package isaPkg;

    // ----------------------------------------------------------------------
    // Opcode space
    // ----------------------------------------------------------------------
    localparam int OpcodeWidth = 7;                        // Opcode field width
    localparam int NumOpcodes  = 2 ** OpcodeWidth;         // 128 opcode slots

    typedef logic [OpcodeWidth-1:0] opcodeT;               // One opcode
    typedef logic [NumOpcodes-1:0]  opHitT;                // One flag per opcode value

    // ----------------------------------------------------------------------
    // Opcode values
    // ----------------------------------------------------------------------
    localparam opcodeT OpLod   = 7'd0;                     // Load acc from memory
    localparam opcodeT OpPLod  = 7'd1;                     // Push, then load
    localparam opcodeT OpLdi   = 7'd2;                     // Indirect load
    localparam opcodeT OpIli   = 7'd3;                     // Indirect load, bit-reversed address
    localparam opcodeT OpSet   = 7'd4;                     // Store acc to memory
    localparam opcodeT OpSetP  = 7'd5;                     // Store, then pop
    localparam opcodeT OpSti   = 7'd6;                     // Indirect store
    localparam opcodeT OpIsi   = 7'd7;                     // Indirect store, bit-reversed address
    localparam opcodeT OpPsh   = 7'd8;                     // Stack push
    localparam opcodeT OpPop   = 7'd9;                     // Stack pop
    localparam opcodeT OpInn   = 7'd10;                    // Input port read
    localparam opcodeT OpPInn  = 7'd11;                    // Push, then input
    localparam opcodeT OpOut   = 7'd12;                    // Output port write
    // 13..16 belong to the jump unit
    localparam opcodeT OpAdd   = 7'd17;
    localparam opcodeT OpAddS  = 7'd18;                    // S suffix: operand from stack
    localparam opcodeT OpMlt   = 7'd21;
    localparam opcodeT OpMltS  = 7'd22;
    localparam opcodeT OpDiv   = 7'd25;
    localparam opcodeT OpDivS  = 7'd26;
    localparam opcodeT OpMod   = 7'd29;
    localparam opcodeT OpModS  = 7'd30;
    localparam opcodeT OpSgn   = 7'd31;
    localparam opcodeT OpSgnS  = 7'd32;
    localparam opcodeT OpNeg   = 7'd35;
    localparam opcodeT OpNegM  = 7'd36;                    // M suffix: operand from memory
    localparam opcodeT OpPNegM = 7'd37;                    // P prefix: push before
    localparam opcodeT OpAbs   = 7'd41;
    localparam opcodeT OpAbsM  = 7'd42;
    localparam opcodeT OpPAbsM = 7'd43;
    localparam opcodeT OpPst   = 7'd47;
    localparam opcodeT OpPstM  = 7'd48;
    localparam opcodeT OpPPstM = 7'd49;
    localparam opcodeT OpAnd   = 7'd62;
    localparam opcodeT OpAndS  = 7'd63;
    localparam opcodeT OpOrr   = 7'd64;
    localparam opcodeT OpOrrS  = 7'd65;
    localparam opcodeT OpXor   = 7'd66;
    localparam opcodeT OpXorS  = 7'd67;
    localparam opcodeT OpInv   = 7'd68;
    localparam opcodeT OpInvM  = 7'd69;
    localparam opcodeT OpPInvM = 7'd70;
    localparam opcodeT OpLan   = 7'd71;
    localparam opcodeT OpLanS  = 7'd72;
    localparam opcodeT OpLor   = 7'd73;
    localparam opcodeT OpLorS  = 7'd74;
    localparam opcodeT OpLin   = 7'd75;
    localparam opcodeT OpLinM  = 7'd76;
    localparam opcodeT OpPLinM = 7'd77;
    localparam opcodeT OpLes   = 7'd78;
    localparam opcodeT OpLesS  = 7'd79;
    localparam opcodeT OpGre   = 7'd82;
    localparam opcodeT OpGreS  = 7'd83;
    localparam opcodeT OpEqu   = 7'd86;
    localparam opcodeT OpEquS  = 7'd87;
    localparam opcodeT OpShl   = 7'd88;
    localparam opcodeT OpShlS  = 7'd89;
    localparam opcodeT OpShr   = 7'd90;
    localparam opcodeT OpShrS  = 7'd91;
    localparam opcodeT OpSrs   = 7'd92;
    localparam opcodeT OpSrsS  = 7'd93;
    localparam opcodeT OpNop   = 7'd94;                    // Holds the ALU code

    // ----------------------------------------------------------------------
    // Default enable mask
    // ----------------------------------------------------------------------
    localparam int NumKept = 60;                           // Instructions in this core

    localparam opcodeT KeptList [NumKept] = '{
        OpLod,  OpPLod, OpLdi,   OpIli,  OpSet,  OpSetP,  OpSti,  OpIsi,
        OpPsh,  OpPop,  OpInn,   OpPInn, OpOut,
        OpAdd,  OpAddS, OpMlt,   OpMltS, OpDiv,  OpDivS,  OpMod,  OpModS,
        OpSgn,  OpSgnS, OpNeg,   OpNegM, OpPNegM,
        OpAbs,  OpAbsM, OpPAbsM, OpPst,  OpPstM, OpPPstM,
        OpAnd,  OpAndS, OpOrr,   OpOrrS, OpXor,  OpXorS,  OpInv,  OpInvM, OpPInvM,
        OpLan,  OpLanS, OpLor,   OpLorS, OpLin,  OpLinM,  OpPLinM,
        OpLes,  OpLesS, OpGre,   OpGreS, OpEqu,  OpEquS,
        OpShl,  OpShlS, OpShr,   OpShrS, OpSrs,  OpSrsS
    };

    function automatic opHitT buildMask();
        opHitT mask;
        mask = '0;
        foreach (KeptList[i]) begin
            mask[KeptList[i]] = 1'b1;                      // Mark each kept slot
        end
        return mask;
    endfunction

    localparam opHitT KeptOpcodes = buildMask();           // Everything kept, all enabled

endpackage

// File: logic/aluPkg.sv
package aluPkg;

    // ----------------------------------------------------------------------
    // ALU operation code
    // ----------------------------------------------------------------------
    localparam int AluOpWidth = 6;

    typedef logic [AluOpWidth-1:0] aluOpT;

    localparam aluOpT AluNone            = 6'd0;           // ALU idle, acc unchanged
    localparam aluOpT AluLoad            = 6'd1;           // Pass operand to acc

    // Integer arithmetic, memory and stack forms share a code
    localparam aluOpT AluAdd             = 6'd2;
    localparam aluOpT AluMult            = 6'd4;
    localparam aluOpT AluDiv             = 6'd6;
    localparam aluOpT AluMod             = 6'd8;
    localparam aluOpT AluSign            = 6'd9;           // Copy sign of one operand to other

    // One-operand forms, Mem variants read memory
    localparam aluOpT AluNeg             = 6'd11;
    localparam aluOpT AluNegMem          = 6'd12;
    localparam aluOpT AluAbs             = 6'd15;
    localparam aluOpT AluAbsMem          = 6'd16;
    localparam aluOpT AluPos             = 6'd19;          // Zero if negative
    localparam aluOpT AluPosMem          = 6'd20;

    // Bitwise
    localparam aluOpT AluAnd             = 6'd29;
    localparam aluOpT AluOr              = 6'd30;
    localparam aluOpT AluXor             = 6'd31;
    localparam aluOpT AluInv             = 6'd32;
    localparam aluOpT AluInvMem          = 6'd33;

    // Logical, result is 0 or 1
    localparam aluOpT AluLogAnd          = 6'd34;
    localparam aluOpT AluLogOr           = 6'd35;
    localparam aluOpT AluLogInv          = 6'd36;
    localparam aluOpT AluLogInvMem       = 6'd37;

    // Compare
    localparam aluOpT AluLess            = 6'd38;
    localparam aluOpT AluGreater         = 6'd40;
    localparam aluOpT AluEqual           = 6'd42;

    // Shift
    localparam aluOpT AluShiftLeft       = 6'd43;
    localparam aluOpT AluShiftRight      = 6'd44;
    localparam aluOpT AluShiftRightArith = 6'd45;          // Keeps sign bit

endpackage

// File: logic/opcodeDecoder.sv
`timescale 1ns/1ps

module opcodeDecoder #(
    parameter isaPkg::opHitT instrEnable = isaPkg::KeptOpcodes   // Per-opcode enable
) (
    input  isaPkg::opcodeT opcode,
    output isaPkg::opHitT  opHit
);

    // ----------------------------------------------------------------------
    // One comparator per opcode slot
    // ----------------------------------------------------------------------
    // Slots outside the kept set never fire, even if enabled by the parent.
    // Jump opcodes 13..16, float variants and NOP all fall into that group.

    for (genvar i = 0; i < isaPkg::NumOpcodes; i++) begin : gHit
        assign opHit[i] = (opcode == isaPkg::opcodeT'(i))   // Value match
                        && isaPkg::KeptOpcodes[i]           // Implemented here
                        && instrEnable[i];                  // Enabled for this core
    end

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------
    // Strobe and ALU logic downstream OR groups of hits together and rely
    // on never seeing two instructions at once
    always_comb begin
        if (!$isunknown(opcode)) begin
            hitOneHot: assert final ($onehot0(opHit))
                else $error("opcodeDecoder: several hits for opcode %0d", opcode);
        end
    end

endmodule

// File: logic/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  logic          clk,                             // Assertion clock only
    input  logic          reset,
    input  isaPkg::opHitT opHit,
    output logic          push,                            // Stack write
    output logic          pop,                             // Stack read
    output logic          memWr,                           // Data memory write
    output logic          ldi,                             // Indirect address select
    output logic          sti,                             // Indirect store
    output logic          fft,                             // Bit-reversed address
    output logic          reqIn,                           // Input port request
    output logic          outEn                            // Output port enable
);

    // ----------------------------------------------------------------------
    // Stack strobes
    // ----------------------------------------------------------------------
    assign push = opHit[isaPkg::OpPLod]  | opHit[isaPkg::OpPsh]   | opHit[isaPkg::OpPInn]
                | opHit[isaPkg::OpPNegM] | opHit[isaPkg::OpPAbsM] | opHit[isaPkg::OpPPstM]
                | opHit[isaPkg::OpPInvM] | opHit[isaPkg::OpPLinM];

    assign pop  = opHit[isaPkg::OpSetP]  | opHit[isaPkg::OpSti]   | opHit[isaPkg::OpIsi]
                | opHit[isaPkg::OpPop]                                       // Explicit pop
                | opHit[isaPkg::OpAddS]  | opHit[isaPkg::OpMltS]  | opHit[isaPkg::OpDivS]
                | opHit[isaPkg::OpModS]  | opHit[isaPkg::OpSgnS]  | opHit[isaPkg::OpAndS]
                | opHit[isaPkg::OpOrrS]  | opHit[isaPkg::OpXorS]  | opHit[isaPkg::OpLanS]
                | opHit[isaPkg::OpLorS]  | opHit[isaPkg::OpLesS]  | opHit[isaPkg::OpGreS]
                | opHit[isaPkg::OpEquS]  | opHit[isaPkg::OpShlS]  | opHit[isaPkg::OpShrS]
                | opHit[isaPkg::OpSrsS];                             // Stack-operand forms

    // ----------------------------------------------------------------------
    // Memory strobes
    // ----------------------------------------------------------------------
    assign memWr = opHit[isaPkg::OpSet] | opHit[isaPkg::OpSetP]
                 | opHit[isaPkg::OpSti] | opHit[isaPkg::OpIsi];
    assign ldi   = opHit[isaPkg::OpLdi] | opHit[isaPkg::OpIli];    // Address from acc
    assign sti   = opHit[isaPkg::OpSti] | opHit[isaPkg::OpIsi];    // Address from stack
    assign fft   = opHit[isaPkg::OpIli] | opHit[isaPkg::OpIsi];    // Reverse address bits

    // ----------------------------------------------------------------------
    // I/O strobes
    // ----------------------------------------------------------------------
    assign reqIn = opHit[isaPkg::OpInn] | opHit[isaPkg::OpPInn];
    assign outEn = opHit[isaPkg::OpOut];

    // Stack pointer moves one way per instruction
    noPushPop: assert property (@(posedge clk) disable iff (reset) !(push && pop))
        else $error("controlUnit: push and pop together");

    // Indirect store always writes the data memory
    stiWrites: assert property (@(posedge clk) disable iff (reset) sti |-> memWr)
        else $error("controlUnit: sti without memWr");

endmodule

// File: logic/aluOpEncoder.sv
`timescale 1ns/1ps

module aluOpEncoder (
    input  logic           clk,
    input  logic           reset,
    input  isaPkg::opcodeT opcode,
    input  isaPkg::opHitT  opHit,
    output aluPkg::aluOpT  aluOp                           // Valid one cycle after opcode
);

    aluPkg::aluOpT nextOp;                                 // Code for the current opcode

    // ----------------------------------------------------------------------
    // Opcode to ALU code table
    // ----------------------------------------------------------------------
    // opHit is one-hot, so the order of the tests does not matter
    always_comb begin
        nextOp = aluPkg::AluNone;                          // Stores, push, I/O, unknown
        if (opHit[isaPkg::OpLod] || opHit[isaPkg::OpPLod] || opHit[isaPkg::OpLdi]
            || opHit[isaPkg::OpIli] || opHit[isaPkg::OpSetP] || opHit[isaPkg::OpPop]) begin
            nextOp = aluPkg::AluLoad;                      // Operand straight into acc
        end
        if (opHit[isaPkg::OpAdd] || opHit[isaPkg::OpAddS]) nextOp = aluPkg::AluAdd;
        if (opHit[isaPkg::OpMlt] || opHit[isaPkg::OpMltS]) nextOp = aluPkg::AluMult;
        if (opHit[isaPkg::OpDiv] || opHit[isaPkg::OpDivS]) nextOp = aluPkg::AluDiv;
        if (opHit[isaPkg::OpMod] || opHit[isaPkg::OpModS]) nextOp = aluPkg::AluMod;
        if (opHit[isaPkg::OpSgn] || opHit[isaPkg::OpSgnS]) nextOp = aluPkg::AluSign;

        if (opHit[isaPkg::OpNeg]) nextOp = aluPkg::AluNeg;
        if (opHit[isaPkg::OpNegM] || opHit[isaPkg::OpPNegM]) nextOp = aluPkg::AluNegMem;
        if (opHit[isaPkg::OpAbs]) nextOp = aluPkg::AluAbs;
        if (opHit[isaPkg::OpAbsM] || opHit[isaPkg::OpPAbsM]) nextOp = aluPkg::AluAbsMem;
        if (opHit[isaPkg::OpPst]) nextOp = aluPkg::AluPos;
        if (opHit[isaPkg::OpPstM] || opHit[isaPkg::OpPPstM]) nextOp = aluPkg::AluPosMem;

        if (opHit[isaPkg::OpAnd] || opHit[isaPkg::OpAndS]) nextOp = aluPkg::AluAnd;
        if (opHit[isaPkg::OpOrr] || opHit[isaPkg::OpOrrS]) nextOp = aluPkg::AluOr;
        if (opHit[isaPkg::OpXor] || opHit[isaPkg::OpXorS]) nextOp = aluPkg::AluXor;
        if (opHit[isaPkg::OpInv]) nextOp = aluPkg::AluInv;
        if (opHit[isaPkg::OpInvM] || opHit[isaPkg::OpPInvM]) nextOp = aluPkg::AluInvMem;

        if (opHit[isaPkg::OpLan] || opHit[isaPkg::OpLanS]) nextOp = aluPkg::AluLogAnd;
        if (opHit[isaPkg::OpLor] || opHit[isaPkg::OpLorS]) nextOp = aluPkg::AluLogOr;
        if (opHit[isaPkg::OpLin]) nextOp = aluPkg::AluLogInv;
        if (opHit[isaPkg::OpLinM] || opHit[isaPkg::OpPLinM]) nextOp = aluPkg::AluLogInvMem;

        if (opHit[isaPkg::OpLes] || opHit[isaPkg::OpLesS]) nextOp = aluPkg::AluLess;
        if (opHit[isaPkg::OpGre] || opHit[isaPkg::OpGreS]) nextOp = aluPkg::AluGreater;
        if (opHit[isaPkg::OpEqu] || opHit[isaPkg::OpEquS]) nextOp = aluPkg::AluEqual;

        if (opHit[isaPkg::OpShl] || opHit[isaPkg::OpShlS]) nextOp = aluPkg::AluShiftLeft;
        if (opHit[isaPkg::OpShr] || opHit[isaPkg::OpShrS]) nextOp = aluPkg::AluShiftRight;
        if (opHit[isaPkg::OpSrs] || opHit[isaPkg::OpSrsS]) begin
            nextOp = aluPkg::AluShiftRightArith;
        end
    end

    // ----------------------------------------------------------------------
    // Code register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            aluOp <= aluPkg::AluNone;
        end else if (opcode != isaPkg::OpNop) begin   // NOP keeps the last code
            aluOp <= nextOp;
        end
    end

    // ALU keeps repeating its last operation through NOP bubbles
    nopHolds: assert property (@(posedge clk) disable iff (reset)
                               opcode == isaPkg::OpNop |=> $stable(aluOp))
        else $error("aluOpEncoder: aluOp changed over a NOP");

endmodule

// File: logic/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder #(
    parameter isaPkg::opHitT instrEnable = isaPkg::KeptOpcodes   // Instruction subset
) (
    input  logic           clk,
    input  logic           reset,
    input  isaPkg::opcodeT opcode,                         // New opcode every cycle
    output logic           push,                           // Strobes, same cycle
    output logic           pop,
    output logic           memWr,
    output logic           ldi,
    output logic           sti,
    output logic           fft,
    output logic           reqIn,
    output logic           outEn,
    output aluPkg::aluOpT  aluOp                           // One cycle later
);

    isaPkg::opHitT opHit;                                  // One-hot instruction match

    // ----------------------------------------------------------------------
    // Decode, strobes, ALU code
    // ----------------------------------------------------------------------
    opcodeDecoder #(
        .instrEnable (instrEnable)
    ) u_opcodeDecoder (
        .opcode (opcode),
        .opHit  (opHit)
    );

    controlUnit u_controlUnit (
        .clk   (clk),
        .reset (reset),
        .opHit (opHit),
        .push  (push),
        .pop   (pop),
        .memWr (memWr),
        .ldi   (ldi),
        .sti   (sti),
        .fft   (fft),
        .reqIn (reqIn),
        .outEn (outEn)
    );

    aluOpEncoder u_aluOpEncoder (
        .clk    (clk),
        .reset  (reset),
        .opcode (opcode),                                  // NOP detect
        .opHit  (opHit),
        .aluOp  (aluOp)
    );

endmodule

// File: testbench/instrDecoderTests.svh
// ----------------------------------------------------------------------
// Reference rules
// ----------------------------------------------------------------------
function automatic logic enabledOp(input isaPkg::opcodeT op);
    return op != isaPkg::OpModS;                           // S_MOD is masked off in the DUT
endfunction

// Bit order: push, pop, memWr, ldi, sti, fft, reqIn, outEn
function automatic logic [7:0] expectedStrobes(input isaPkg::opcodeT op);
    logic [7:0] s;
    s = '0;
    if (enabledOp(op)) begin
        case (op)
            isaPkg::OpPLod, isaPkg::OpPsh, isaPkg::OpPNegM, isaPkg::OpPAbsM,
            isaPkg::OpPPstM, isaPkg::OpPInvM, isaPkg::OpPLinM: s = 8'b1000_0000;
            isaPkg::OpPInn: s = 8'b1000_0010;              // Push plus input request
            isaPkg::OpPop, isaPkg::OpAddS, isaPkg::OpMltS, isaPkg::OpDivS, isaPkg::OpModS,
            isaPkg::OpSgnS, isaPkg::OpAndS, isaPkg::OpOrrS, isaPkg::OpXorS, isaPkg::OpLanS,
            isaPkg::OpLorS, isaPkg::OpLesS, isaPkg::OpGreS, isaPkg::OpEquS, isaPkg::OpShlS,
            isaPkg::OpShrS, isaPkg::OpSrsS: s = 8'b0100_0000;
            isaPkg::OpSet:  s = 8'b0010_0000;
            isaPkg::OpSetP: s = 8'b0110_0000;              // Write, then pop
            isaPkg::OpSti:  s = 8'b0110_1000;
            isaPkg::OpIsi:  s = 8'b0110_1100;              // Indirect store, reversed address
            isaPkg::OpLdi:  s = 8'b0001_0000;
            isaPkg::OpIli:  s = 8'b0001_0100;
            isaPkg::OpInn:  s = 8'b0000_0010;
            isaPkg::OpOut:  s = 8'b0000_0001;
            default:        s = 8'b0000_0000;              // ALU ops, NOP, unknown
        endcase
    end
    return s;
endfunction

function automatic aluPkg::aluOpT expectedAlu(input isaPkg::opcodeT op);
    aluPkg::aluOpT a;
    a = aluPkg::AluNone;
    if (enabledOp(op)) begin
        case (op)
            isaPkg::OpLod, isaPkg::OpPLod, isaPkg::OpLdi, isaPkg::OpIli,
            isaPkg::OpSetP, isaPkg::OpPop:        a = aluPkg::AluLoad;
            isaPkg::OpAdd, isaPkg::OpAddS:        a = aluPkg::AluAdd;
            isaPkg::OpMlt, isaPkg::OpMltS:        a = aluPkg::AluMult;
            isaPkg::OpDiv, isaPkg::OpDivS:        a = aluPkg::AluDiv;
            isaPkg::OpMod, isaPkg::OpModS:        a = aluPkg::AluMod;
            isaPkg::OpSgn, isaPkg::OpSgnS:        a = aluPkg::AluSign;
            isaPkg::OpNeg:                        a = aluPkg::AluNeg;
            isaPkg::OpNegM, isaPkg::OpPNegM:      a = aluPkg::AluNegMem;
            isaPkg::OpAbs:                        a = aluPkg::AluAbs;
            isaPkg::OpAbsM, isaPkg::OpPAbsM:      a = aluPkg::AluAbsMem;
            isaPkg::OpPst:                        a = aluPkg::AluPos;
            isaPkg::OpPstM, isaPkg::OpPPstM:      a = aluPkg::AluPosMem;
            isaPkg::OpAnd, isaPkg::OpAndS:        a = aluPkg::AluAnd;
            isaPkg::OpOrr, isaPkg::OpOrrS:        a = aluPkg::AluOr;
            isaPkg::OpXor, isaPkg::OpXorS:        a = aluPkg::AluXor;
            isaPkg::OpInv:                        a = aluPkg::AluInv;
            isaPkg::OpInvM, isaPkg::OpPInvM:      a = aluPkg::AluInvMem;
            isaPkg::OpLan, isaPkg::OpLanS:        a = aluPkg::AluLogAnd;
            isaPkg::OpLor, isaPkg::OpLorS:        a = aluPkg::AluLogOr;
            isaPkg::OpLin:                        a = aluPkg::AluLogInv;
            isaPkg::OpLinM, isaPkg::OpPLinM:      a = aluPkg::AluLogInvMem;
            isaPkg::OpLes, isaPkg::OpLesS:        a = aluPkg::AluLess;
            isaPkg::OpGre, isaPkg::OpGreS:        a = aluPkg::AluGreater;
            isaPkg::OpEqu, isaPkg::OpEquS:        a = aluPkg::AluEqual;
            isaPkg::OpShl, isaPkg::OpShlS:        a = aluPkg::AluShiftLeft;
            isaPkg::OpShr, isaPkg::OpShrS:        a = aluPkg::AluShiftRight;
            isaPkg::OpSrs, isaPkg::OpSrsS:        a = aluPkg::AluShiftRightArith;
            default:                              a = aluPkg::AluNone;   // Stores, push, I/O
        endcase
    end
    return a;
endfunction

// ----------------------------------------------------------------------
// Driver, one opcode per cycle
// ----------------------------------------------------------------------
task automatic driveOp(input string testName, input isaPkg::opcodeT op);
    @(posedge clk);                                        // Previous opcode registered here
    if (lastOp != isaPkg::OpNop) begin
        modelAlu = expectedAlu(lastOp);
    end
    #1;
    opcode = op;
    lastOp = op;
    @(negedge clk);                                        // Strobes settled, aluOp stable
    checkStrobes(testName, expectedStrobes(op), {push, pop, memWr, ldi, sti, fft, reqIn, outEn});
    checkAluOp(testName, modelAlu, aluOp);
endtask

// ----------------------------------------------------------------------
// Directed tests
// ----------------------------------------------------------------------
task automatic testAfterReset();
    repeat (3) driveOp("afterReset", isaPkg::OpNop);
    checkAluOp("afterReset", aluPkg::AluNone, aluOp);      // Register cleared by reset
    reportTest("afterReset");
endtask

task automatic testMemStackIo();
    for (int i = 0; i <= 12; i++) begin
        driveOp("memStackIo", isaPkg::opcodeT'(i));        // LOD through OUT
    end
    reportTest("memStackIo");
endtask

task automatic testAluCodes();
    for (int i = 17; i <= 94; i++) begin
        driveOp("aluCodes", isaPkg::opcodeT'(i));          // Back to back, ends on NOP
    end
    reportTest("aluCodes");
endtask

task automatic testNopHold();
    isaPkg::opcodeT ops [4] = '{isaPkg::OpAdd, isaPkg::OpShrS, isaPkg::OpLod, isaPkg::OpPInvM};
    foreach (ops[i]) begin
        driveOp("nopHold", ops[i]);
        repeat (4) driveOp("nopHold", isaPkg::OpNop);      // Code must not move
    end
    reportTest("nopHold");
endtask

task automatic testUnknownOps();
    isaPkg::opcodeT badOps [18] = '{7'd13, 7'd14, 7'd15, 7'd16, 7'd19, 7'd23, 7'd27, 7'd33,
                                    7'd38, 7'd50, 7'd55, 7'd61, 7'd80, 7'd84, 7'd95, 7'd100,
                                    7'd127, isaPkg::OpModS};
    foreach (badOps[i]) begin
        driveOp("unknownOps", isaPkg::OpXor);              // Nonzero code before each
        driveOp("unknownOps", badOps[i]);
    end
    driveOp("unknownOps", isaPkg::OpNop);                  // Shows the last result
    reportTest("unknownOps");
endtask

task automatic testRandomOps();
    repeat (200) driveOp("randomOps", isaPkg::opcodeT'($urandom_range(127, 0)));
    driveOp("randomOps", isaPkg::OpNop);
    reportTest("randomOps");
endtask

// File: testbench/instrDecoderTb.sv
`timescale 1ns/1ps

module instrDecoderTb;

    localparam int CycleLimit = 600;                       // About twice the test length
    localparam isaPkg::opHitT DutEnable =
        isaPkg::KeptOpcodes & ~(isaPkg::opHitT'(1) << isaPkg::OpModS);   // S_MOD off

    logic           clk;
    logic           reset;
    isaPkg::opcodeT opcode;
    logic           push, pop, memWr, ldi, sti, fft, reqIn, outEn;
    aluPkg::aluOpT  aluOp;

    aluPkg::aluOpT  modelAlu;                              // Expected contents of the code register
    isaPkg::opcodeT lastOp;                                // Opcode driven in the previous cycle
    int             cycleCount = 0;
    int             checkCount = 0;
    int             errorCount = 0;
    int             testErrors = 0;                        // Errors in the running test

    instrDecoder #(
        .instrEnable (DutEnable)
    ) u_dut (
        .clk   (clk),
        .reset (reset),
        .opcode (opcode),
        .push  (push),
        .pop   (pop),
        .memWr (memWr),
        .ldi   (ldi),
        .sti   (sti),
        .fft   (fft),
        .reqIn (reqIn),
        .outEn (outEn),
        .aluOp (aluOp)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;                                 // 100 ns period

    // ----------------------------------------------------------------------
    // Run limit
    // ----------------------------------------------------------------------
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("Timeout: tests still running after %0d cycles", CycleLimit);
            $display("Testbench failed");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------
    task automatic checkStrobes(input string testName, input logic [7:0] expected,
                                input logic [7:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            testErrors++;
            $display("** Error %s: strobes expected %b, actual %b", testName, expected, actual);
        end
    endtask

    task automatic checkAluOp(input string testName, input aluPkg::aluOpT expected,
                              input aluPkg::aluOpT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            testErrors++;
            $display("** Error %s: aluOp expected %0d, actual %0d", testName, expected, actual);
        end
    endtask

    task automatic reportTest(input string testName);
        $display("Test %s done, %0d errors", testName, testErrors);
        testErrors = 0;
    endtask

    `include "instrDecoderTests.svh"

    initial begin
        void'($urandom(33375));                            // One seed for the whole run
        reset    = 1'b1;
        opcode   = isaPkg::OpNop;
        modelAlu = aluPkg::AluNone;
        lastOp   = isaPkg::OpNop;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        testAfterReset();
        testMemStackIo();
        testAluCodes();
        testNopHold();
        testUnknownOps();
        testRandomOps();

        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+testbench
logic/isaPkg.sv
logic/aluPkg.sv
logic/opcodeDecoder.sv
logic/controlUnit.sv
logic/aluOpEncoder.sv
logic/instrDecoder.sv
testbench/instrDecoderTb.sv
